/* Makefile */
TOP := tb_fir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f build.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir

/* build.f */
fir_pkg.sv
fir_tap_file.sv
fir_axil_regs.sv
fir_mac_engine.sv
fir_top.sv
tb_clock_gen.sv
tb_fir.sv

/* fir_axil_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module fir_axil_regs #(
    parameter int num_taps = 11
) (
    input  wire                     axis_clk,
    input  wire                     axis_rst_n,
    input  wire                     awvalid,
    input  wire fir_pkg::addr_t     awaddr,
    output logic                    awready,
    input  wire                     wvalid,
    input  wire fir_pkg::data_t     wdata,
    output logic                    wready,
    input  wire                     arvalid,
    input  wire fir_pkg::addr_t     araddr,
    output logic                    arready,
    output logic                    rvalid,
    output fir_pkg::data_t          rdata,
    input  wire                     rready,
    output logic                    tap_wr_en,
    output fir_pkg::tap_idx_t       tap_wr_idx,
    output fir_pkg::data_t          tap_wr_data,
    output fir_pkg::tap_idx_t       tap_rd_idx,
    input  wire fir_pkg::data_t     tap_rd_data,
    output logic                    start,
    input  wire                     first_accept,
    input  wire                     block_done
);
    import fir_pkg::*;

    lite_wr_state_t wr_state;
    lite_rd_state_t rd_state;
    addr_t          wr_addr;
    logic           wr_hs;
    logic           rd_is_ctrl;
    logic           ap_start;
    logic           ap_done;
    logic           ap_idle;
    data_t          data_len;
    data_t          rd_mux;

    // Word-aligned slot inside the tap region
    function automatic logic is_tap_addr(addr_t a);
        return (a >= TAP_BASE_ADDR) && (a < TAP_BASE_ADDR + addr_t'(4 * num_taps))
            && (a[1:0] == 2'b00);
    endfunction

    function automatic tap_idx_t tap_index(addr_t a);
        addr_t off;
        off = a - TAP_BASE_ADDR;
        return off[5:2];
    endfunction

    assign awready = (wr_state == WR_ADDR);
    assign wready  = (wr_state == WR_DATA);
    assign arready = (rd_state == RD_ADDR);
    assign rvalid  = (rd_state == RD_DATA);
    assign wr_hs   = wvalid & wready;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wr_state <= WR_ADDR;
        end else if (wr_state == WR_ADDR && awvalid) begin
            wr_state <= WR_DATA;
        end else if (wr_state == WR_DATA && wvalid) begin
            wr_state <= WR_ADDR;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (awvalid && awready) begin
            wr_addr <= awaddr;
        end
    end

    // Taps and start are locked out while a block runs
    assign tap_wr_en   = wr_hs & ap_idle & is_tap_addr(wr_addr);
    assign tap_wr_idx  = tap_index(wr_addr);
    assign tap_wr_data = wdata;
    assign start       = wr_hs & ap_idle & (wr_addr == AP_CTRL_ADDR) & wdata[0];

    assign tap_rd_idx = tap_index(araddr);

    always_comb begin
        if (araddr == AP_CTRL_ADDR) begin
            rd_mux = {29'b0, ap_idle, ap_done, ap_start};
        end else if (araddr == DATA_LEN_ADDR) begin
            rd_mux = data_len;
        end else if (is_tap_addr(araddr)) begin
            rd_mux = tap_rd_data;
        end else begin
            rd_mux = '0;
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            rd_state <= RD_ADDR;
        end else if (rd_state == RD_ADDR && arvalid) begin
            rd_state <= RD_DATA;
        end else if (rd_state == RD_DATA && rready) begin
            rd_state <= RD_ADDR;
        end
    end

    // Read data is captured at address time and held until taken
    always_ff @(posedge axis_clk) begin
        if (arvalid && arready) begin
            rdata      <= rd_mux;
            rd_is_ctrl <= (araddr == AP_CTRL_ADDR);
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ap_start <= 1'b0;
            ap_done  <= 1'b0;
            ap_idle  <= 1'b1;
            data_len <= '0;
        end else begin
            if (start) begin
                ap_start <= 1'b1;
                ap_idle  <= 1'b0;
            end else if (first_accept) begin
                ap_start <= 1'b0;
            end
            // Done is cleared only by a read that actually reported it
            if (block_done) begin
                ap_done <= 1'b1;
                ap_idle <= 1'b1;
            end else if (rvalid && rready && rd_is_ctrl && rdata[1]) begin
                ap_done <= 1'b0;
            end
            if (wr_hs && ap_idle && wr_addr == DATA_LEN_ADDR) begin
                data_len <= wdata;
            end
        end
    end

    a_rdata_hold: assert property (
        @(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata)
    ) else $error("rdata changed while waiting for rready");

    // No start while an earlier one is still waiting for its first sample
    a_start_idle: assert property (
        @(posedge axis_clk) disable iff (!axis_rst_n)
        start |-> !ap_start ##1 (ap_start && !ap_idle && !start)
    ) else $error("start pulse while a block is pending or longer than one cycle");

endmodule

`default_nettype wire

/* fir_mac_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module fir_mac_engine #(
    parameter int num_taps = 11
) (
    input  wire                     axis_clk,
    input  wire                     axis_rst_n,
    input  wire                     start,
    output logic                    first_accept,
    output logic                    block_done,
    input  wire                     ss_tvalid,
    input  wire fir_pkg::data_t     ss_tdata,
    input  wire                     ss_tlast,
    output logic                    ss_tready,
    input  wire                     sm_tready,
    output logic                    sm_tvalid,
    output fir_pkg::data_t          sm_tdata,
    output logic                    sm_tlast,
    output fir_pkg::tap_idx_t       tap_idx,
    input  wire fir_pkg::data_t     tap_data
);
    import fir_pkg::*;

    engine_state_t state;
    data_t         hist [num_taps];
    data_t         acc;
    data_t         product;
    tap_idx_t      tap_cnt;
    logic          first_q;
    logic          last_q;
    logic          out_valid;
    logic          accept;
    logic          out_hs;

    assign ss_tready = (state == ENG_ACCEPT);
    assign accept    = ss_tvalid & ss_tready;

    assign sm_tvalid = out_valid;
    assign sm_tdata  = acc;
    assign sm_tlast  = out_valid & last_q;
    assign out_hs    = out_valid & sm_tready;

    assign first_accept = accept & first_q;
    assign block_done   = out_hs & last_q;

    // Tap k pairs with the sample k steps back
    assign tap_idx = tap_cnt;
    assign product = tap_data * hist[tap_cnt];

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state     <= ENG_IDLE;
            tap_cnt   <= '0;
            first_q   <= 1'b0;
            last_q    <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            case (state)
                ENG_IDLE: begin
                    if (start) begin
                        state   <= ENG_ACCEPT;
                        first_q <= 1'b1;
                    end
                end
                ENG_ACCEPT: begin
                    if (ss_tvalid) begin
                        state   <= ENG_MAC;
                        tap_cnt <= '0;
                        last_q  <= ss_tlast;
                        first_q <= 1'b0;
                    end
                end
                ENG_MAC: begin
                    if (tap_cnt == tap_idx_t'(num_taps - 1)) begin
                        state <= ENG_OUTPUT;
                    end else begin
                        tap_cnt <= tap_cnt + 1'b1;
                    end
                end
                ENG_OUTPUT: begin
                    // First cycle raises valid, then wait for the sink
                    if (!out_valid) begin
                        out_valid <= 1'b1;
                    end else if (sm_tready) begin
                        out_valid <= 1'b0;
                        state     <= last_q ? ENG_IDLE : ENG_ACCEPT;
                    end
                end
                default: begin
                    state <= ENG_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge axis_clk) begin
        // Every block starts from an empty history
        if (state == ENG_IDLE && start) begin
            for (int i = 0; i < num_taps; i++) begin
                hist[i] <= '0;
            end
        end
        if (accept) begin
            hist[0] <= ss_tdata;
            for (int i = 1; i < num_taps; i++) begin
                hist[i] <= hist[i - 1];
            end
            acc <= '0;
        end else if (state == ENG_MAC) begin
            // Wraps modulo 2^32
            acc <= acc + product;
        end
    end

    a_one_in_flight: assert property (
        @(posedge axis_clk) disable iff (!axis_rst_n)
        !(ss_tready && sm_tvalid)
    ) else $error("input accepted while a result is pending");

    a_output_hold: assert property (
        @(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast)
    ) else $error("output stream changed under back-pressure");

endmodule

`default_nettype wire

/* fir_pkg.sv */
`default_nettype none

package fir_pkg;

    // One word on every data path, taps and register data included
    typedef logic signed [31:0] data_t;

    // Lite port byte address
    typedef logic [11:0] addr_t;

    // Tap or history slot
    typedef logic [3:0] tap_idx_t;

    // Register map
    localparam addr_t AP_CTRL_ADDR  = 12'h000;
    localparam addr_t DATA_LEN_ADDR = 12'h010;
    localparam addr_t TAP_BASE_ADDR = 12'h020;

    typedef enum logic {
        WR_ADDR,
        WR_DATA
    } lite_wr_state_t;

    typedef enum logic {
        RD_ADDR,
        RD_DATA
    } lite_rd_state_t;

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_ACCEPT,
        ENG_MAC,
        ENG_OUTPUT
    } engine_state_t;

endpackage

`default_nettype wire

/* fir_tap_file.sv */
`timescale 1ns/1ps
`default_nettype none

module fir_tap_file #(
    parameter int num_taps = 11
) (
    input  wire                     axis_clk,
    input  wire                     axis_rst_n,
    input  wire                     wr_en,
    input  wire fir_pkg::tap_idx_t  wr_idx,
    input  wire fir_pkg::data_t     wr_data,
    input  wire fir_pkg::tap_idx_t  rd_a_idx,
    output fir_pkg::data_t          rd_a_data,
    input  wire fir_pkg::tap_idx_t  rd_b_idx,
    output fir_pkg::data_t          rd_b_data
);
    import fir_pkg::*;

    data_t taps [num_taps];

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            for (int i = 0; i < num_taps; i++) begin
                taps[i] <= '0;
            end
        end else if (wr_en && wr_idx < num_taps) begin
            taps[wr_idx] <= wr_data;
        end
    end

    // Host readback port
    assign rd_a_data = (rd_a_idx < num_taps) ? taps[rd_a_idx] : '0;

    // Engine port
    assign rd_b_data = (rd_b_idx < num_taps) ? taps[rd_b_idx] : '0;

    // Register decode must never produce a slot beyond the file
    a_wr_idx_range: assert property (
        @(posedge axis_clk) disable iff (!axis_rst_n)
        wr_en |-> wr_idx < num_taps
    ) else $error("tap write index %0d out of range", wr_idx);

endmodule

`default_nettype wire

/* fir_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fir_top #(
    parameter int num_taps = 11
) (
    input  wire                     axis_clk,
    input  wire                     axis_rst_n,
    input  wire                     awvalid,
    input  wire fir_pkg::addr_t     awaddr,
    output wire                     awready,
    input  wire                     wvalid,
    input  wire fir_pkg::data_t     wdata,
    output wire                     wready,
    input  wire                     arvalid,
    input  wire fir_pkg::addr_t     araddr,
    output wire                     arready,
    output wire                     rvalid,
    output wire fir_pkg::data_t     rdata,
    input  wire                     rready,
    input  wire                     ss_tvalid,
    input  wire fir_pkg::data_t     ss_tdata,
    input  wire                     ss_tlast,
    output wire                     ss_tready,
    input  wire                     sm_tready,
    output wire                     sm_tvalid,
    output wire fir_pkg::data_t     sm_tdata,
    output wire                     sm_tlast
);
    import fir_pkg::*;

    logic     tap_wr_en;
    tap_idx_t tap_wr_idx;
    data_t    tap_wr_data;
    tap_idx_t tap_rd_idx;
    data_t    tap_rd_data;
    tap_idx_t eng_tap_idx;
    data_t    eng_tap_data;
    logic     start;
    logic     first_accept;
    logic     block_done;

    fir_axil_regs #(
        .num_taps (num_taps)
    ) u_regs (
        .axis_clk     (axis_clk),
        .axis_rst_n   (axis_rst_n),
        .awvalid      (awvalid),
        .awaddr       (awaddr),
        .awready      (awready),
        .wvalid       (wvalid),
        .wdata        (wdata),
        .wready       (wready),
        .arvalid      (arvalid),
        .araddr       (araddr),
        .arready      (arready),
        .rvalid       (rvalid),
        .rdata        (rdata),
        .rready       (rready),
        .tap_wr_en    (tap_wr_en),
        .tap_wr_idx   (tap_wr_idx),
        .tap_wr_data  (tap_wr_data),
        .tap_rd_idx   (tap_rd_idx),
        .tap_rd_data  (tap_rd_data),
        .start        (start),
        .first_accept (first_accept),
        .block_done   (block_done)
    );

    // Port A serves the host, port B the engine
    fir_tap_file #(
        .num_taps (num_taps)
    ) u_taps (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .wr_en      (tap_wr_en),
        .wr_idx     (tap_wr_idx),
        .wr_data    (tap_wr_data),
        .rd_a_idx   (tap_rd_idx),
        .rd_a_data  (tap_rd_data),
        .rd_b_idx   (eng_tap_idx),
        .rd_b_data  (eng_tap_data)
    );

    fir_mac_engine #(
        .num_taps (num_taps)
    ) u_engine (
        .axis_clk     (axis_clk),
        .axis_rst_n   (axis_rst_n),
        .start        (start),
        .first_accept (first_accept),
        .block_done   (block_done),
        .ss_tvalid    (ss_tvalid),
        .ss_tdata     (ss_tdata),
        .ss_tlast     (ss_tlast),
        .ss_tready    (ss_tready),
        .sm_tready    (sm_tready),
        .sm_tvalid    (sm_tvalid),
        .sm_tdata     (sm_tdata),
        .sm_tlast     (sm_tlast),
        .tap_idx      (eng_tap_idx),
        .tap_data     (eng_tap_data)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 16
) (
    output logic axis_clk,
    output logic axis_rst_n
);

    initial begin
        axis_clk = 1'b0;
        forever begin
            #(period_ns / 2);
            axis_clk = ~axis_clk;
        end
    end

    // Release on a falling edge, away from the DUT's sampling edge
    initial begin
        axis_rst_n = 1'b0;
        repeat (reset_cycles) @(posedge axis_clk);
        @(negedge axis_clk);
        axis_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* tb_fir.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fir;
    import fir_pkg::*;

    localparam int num_taps   = 11;
    localparam int wait_limit = 200;

    logic  axis_clk;
    logic  axis_rst_n;
    logic  awvalid;
    addr_t awaddr;
    logic  awready;
    logic  wvalid;
    data_t wdata;
    logic  wready;
    logic  arvalid;
    addr_t araddr;
    logic  arready;
    logic  rvalid;
    data_t rdata;
    logic  rready;
    logic  ss_tvalid;
    data_t ss_tdata;
    logic  ss_tlast;
    logic  ss_tready;
    logic  sm_tready;
    logic  sm_tvalid;
    data_t sm_tdata;
    logic  sm_tlast;

    int          cycle = 0;
    int          hs_cycle;
    int          err_count = 0;
    int          check_count = 0;
    bit          timed_out = 1'b0;
    logic [31:0] lfsr_state = 32'h5a7b_17f3;
    data_t       tap_ref [num_taps];
    data_t       samples [32];

    tb_clock_gen #(
        .period_ns    (40),
        .reset_cycles (16)
    ) u_clk (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n)
    );

    fir_top #(
        .num_taps (num_taps)
    ) UUT (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awready    (awready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wready     (wready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .rready     (rready),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tlast   (ss_tlast),
        .ss_tready  (ss_tready),
        .sm_tready  (sm_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast)
    );

    always @(posedge axis_clk) begin
        cycle <= cycle + 1;
    end

    // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic take_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic data_t random_word();
        data_t w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], take_bit()};
        end
        return w;
    endfunction

    // Direct form over the block, zero history before sample 0
    function automatic data_t model_output(int n);
        data_t acc;
        acc = '0;
        for (int k = 0; k < num_taps; k++) begin
            if (n - k >= 0) begin
                acc = acc + tap_ref[k] * samples[n - k];
            end
        end
        return acc;
    endfunction

    task automatic check_data(input string name, input data_t got, input data_t exp);
        check_count++;
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic note_timeout(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        err_count++;
        timed_out = 1'b1;
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("%s: pass", name);
        end else begin
            $display("%s: FAIL with %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic lite_write(input addr_t addr, input data_t data);
        int cnt;
        if (timed_out) return;
        @(negedge axis_clk);
        awvalid = 1'b1;
        awaddr  = addr;
        cnt = 0;
        while (!awready && !timed_out) begin
            @(negedge axis_clk);
            cnt++;
            if (cnt > wait_limit) begin
                note_timeout("awready");
            end
        end
        @(negedge axis_clk);
        awvalid = 1'b0;
        wvalid  = 1'b1;
        wdata   = data;
        cnt = 0;
        while (!wready && !timed_out) begin
            @(negedge axis_clk);
            cnt++;
            if (cnt > wait_limit) begin
                note_timeout("wready");
            end
        end
        @(negedge axis_clk);
        wvalid = 1'b0;
    endtask

    task automatic lite_read(input addr_t addr, output data_t data);
        int cnt;
        data = '0;
        if (timed_out) return;
        @(negedge axis_clk);
        arvalid = 1'b1;
        araddr  = addr;
        cnt = 0;
        while (!arready && !timed_out) begin
            @(negedge axis_clk);
            cnt++;
            if (cnt > wait_limit) begin
                note_timeout("arready");
            end
        end
        @(negedge axis_clk);
        arvalid = 1'b0;
        rready  = 1'b1;
        cnt = 0;
        while (!rvalid && !timed_out) begin
            @(negedge axis_clk);
            cnt++;
            if (cnt > wait_limit) begin
                note_timeout("rvalid");
            end
        end
        data = rdata;
        @(negedge axis_clk);
        rready = 1'b0;
    endtask

    task automatic read_expect(input string name, input addr_t addr, input data_t exp);
        data_t rd;
        lite_read(addr, rd);
        if (!timed_out) begin
            check_data(name, rd, exp);
        end
    endtask

    task automatic stream_send(input data_t d, input logic last);
        int cnt;
        if (timed_out) return;
        @(negedge axis_clk);
        ss_tvalid = 1'b1;
        ss_tdata  = d;
        ss_tlast  = last;
        cnt = 0;
        while (!ss_tready && !timed_out) begin
            @(negedge axis_clk);
            cnt++;
            if (cnt > wait_limit) begin
                note_timeout("ss_tready");
            end
        end
        // The handshake completes on the coming rising edge
        hs_cycle = cycle + 1;
        @(negedge axis_clk);
        ss_tvalid = 1'b0;
        ss_tlast  = 1'b0;
    endtask

    task automatic collect_one(input bit random_ready, output data_t data,
                               output logic last, output int rise);
        int cnt;
        bit got;
        bit seen;
        cnt  = 0;
        got  = 1'b0;
        seen = 1'b0;
        rise = 0;
        data = '0;
        last = 1'b0;
        while (!got && !timed_out) begin
            sm_tready = random_ready ? take_bit() : 1'b1;
            if (sm_tvalid && !seen) begin
                seen = 1'b1;
                rise = cycle;
            end
            if (sm_tvalid && sm_tready) begin
                got  = 1'b1;
                data = sm_tdata;
                last = sm_tlast;
            end
            @(negedge axis_clk);
            cnt++;
            if (!got && cnt > wait_limit) begin
                note_timeout("sm_tvalid");
            end
        end
        sm_tready = 1'b0;
    endtask

    // Host accesses while the engine waits for its second sample
    task automatic probe_busy();
        lite_write(TAP_BASE_ADDR, ~tap_ref[0]);
        lite_write(AP_CTRL_ADDR, 32'd1);
        read_expect("ap_ctrl while busy", AP_CTRL_ADDR, 32'd0);
    endtask

    task automatic run_block(input int n, input bit random_ready,
                             input bit check_latency, input int probe_at);
        data_t got;
        logic  got_last;
        int    rise;
        for (int i = 0; i < n; i++) begin
            stream_send(samples[i], i == n - 1);
            collect_one(random_ready, got, got_last, rise);
            if (timed_out) return;
            check_data($sformatf("sm_tdata[%0d]", i), got, model_output(i));
            check_bit($sformatf("sm_tlast[%0d]", i), got_last, i == n - 1);
            if (check_latency) begin
                check_count++;
                if (rise - hs_cycle != num_taps + 1) begin
                    $display("Output %0d came %0d cycles after its input handshake, not %0d",
                             i, rise - hs_cycle, num_taps + 1);
                    err_count++;
                end
            end
            if (i == probe_at) begin
                probe_busy();
            end
        end
        check_bit("ss_tready after block", ss_tready, 1'b0);
        check_bit("sm_tvalid after block", sm_tvalid, 1'b0);
    endtask

    task automatic write_taps();
        for (int i = 0; i < num_taps; i++) begin
            lite_write(TAP_BASE_ADDR + addr_t'(4 * i), tap_ref[i]);
        end
    endtask

    task automatic test_reset();
        int errs;
        errs = err_count;
        check_bit("awready", awready, 1'b1);
        check_bit("arready", arready, 1'b1);
        check_bit("wready", wready, 1'b0);
        check_bit("rvalid", rvalid, 1'b0);
        check_bit("ss_tready", ss_tready, 1'b0);
        check_bit("sm_tvalid", sm_tvalid, 1'b0);
        check_bit("sm_tlast", sm_tlast, 1'b0);
        read_expect("ap_ctrl", AP_CTRL_ADDR, 32'd4);
        report_test("reset state", errs);
    endtask

    task automatic test_readback();
        int    errs;
        data_t len;
        errs = err_count;
        for (int i = 0; i < num_taps; i++) begin
            tap_ref[i] = random_word();
        end
        len = random_word();
        write_taps();
        lite_write(DATA_LEN_ADDR, len);
        for (int i = 0; i < num_taps; i++) begin
            read_expect($sformatf("tap[%0d]", i), TAP_BASE_ADDR + addr_t'(4 * i), tap_ref[i]);
        end
        read_expect("data_len", DATA_LEN_ADDR, len);
        read_expect("unmapped 0x100", 12'h100, 32'd0);
        report_test("register readback", errs);
    endtask

    task automatic test_impulse();
        int errs;
        errs = err_count;
        for (int i = 0; i < num_taps; i++) begin
            tap_ref[i] = data_t'(37 * (i + 1) - 200);
            samples[i] = (i == 0) ? 32'd1 : 32'd0;
        end
        write_taps();
        lite_write(AP_CTRL_ADDR, 32'd1);
        run_block(num_taps, 1'b0, 1'b1, -1);
        read_expect("ap_ctrl after block", AP_CTRL_ADDR, 32'd6);
        report_test("impulse response", errs);
    endtask

    task automatic test_backpressure();
        int errs;
        errs = err_count;
        for (int i = 0; i < num_taps; i++) begin
            tap_ref[i] = random_word();
        end
        for (int i = 0; i < 20; i++) begin
            samples[i] = random_word();
        end
        write_taps();
        lite_write(AP_CTRL_ADDR, 32'd1);
        run_block(20, 1'b1, 1'b0, -1);
        read_expect("ap_ctrl after block", AP_CTRL_ADDR, 32'd6);
        report_test("random block under back-pressure", errs);
    endtask

    task automatic test_control();
        int errs;
        errs = err_count;
        for (int i = 0; i < 5; i++) begin
            samples[i] = random_word();
        end
        lite_write(AP_CTRL_ADDR, 32'd1);
        run_block(5, 1'b1, 1'b0, 0);
        read_expect("ap_ctrl with done", AP_CTRL_ADDR, 32'd6);
        read_expect("ap_ctrl after done read", AP_CTRL_ADDR, 32'd4);
        read_expect("tap[0] after busy write", TAP_BASE_ADDR, tap_ref[0]);
        // Second block must see an empty history again
        for (int i = 0; i < 6; i++) begin
            samples[i] = random_word();
        end
        lite_write(AP_CTRL_ADDR, 32'd1);
        run_block(6, 1'b1, 1'b0, -1);
        read_expect("ap_ctrl after second block", AP_CTRL_ADDR, 32'd6);
        report_test("control protocol", errs);
    endtask

    initial begin
        int cnt;
        awvalid   = 1'b0;
        awaddr    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        arvalid   = 1'b0;
        araddr    = '0;
        rready    = 1'b0;
        ss_tvalid = 1'b0;
        ss_tdata  = '0;
        ss_tlast  = 1'b0;
        sm_tready = 1'b0;
        cnt = 0;
        while (axis_rst_n !== 1'b1 && !timed_out) begin
            @(negedge axis_clk);
            cnt++;
            if (cnt > wait_limit) begin
                note_timeout("reset release");
            end
        end
        if (!timed_out) test_reset();
        if (!timed_out) test_readback();
        if (!timed_out) test_impulse();
        if (!timed_out) test_backpressure();
        if (!timed_out) test_control();
        $display("Finished: %0d checks, %0d failures", check_count, err_count);
        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Overall limit on simulated time
    initial begin
        #2_000_000;
        $display("Simulation ran past its time limit");
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire
